// File: Bender.yml
package:
  name: ls_buffer

sources:
  - include_dirs:
      - include
    files:
      - design/ls_types_pkg.sv
      - design/ls_ctrl_pkg.sv
      - design/ls_head_if.sv
      - design/ls_entry.sv
      - design/ls_queue.sv
      - design/ls_mem_ctrl.sv
      - design/ls_buffer_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/ls_buffer_properties.sv
      - test/ls_buffer_tb.sv

// File: design/ls_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module ls_buffer_top (
	input  logic                     clk,
	input  logic                     rst_n,
	// allocation
	input  logic                     alloc_valid_i,
	input  ls_types_pkg::ls_op_e     alloc_op_i,
	input  ls_types_pkg::addr_t      alloc_base_i,
	input  ls_types_pkg::addr_t      alloc_offset_i,
	input  ls_types_pkg::data_t      alloc_data_i,
	input  ls_types_pkg::tag_t       alloc_tag_i,
	output logic                     alloc_ready_o,
	// common data bus
	input  logic                     cdb_valid_i,
	input  ls_types_pkg::tag_t       cdb_tag_i,
	input  ls_types_pkg::data_t      cdb_data_i,
	// AXI4-Lite master
	output logic                     awvalid_o,
	input  logic                     awready_i,
	output ls_types_pkg::addr_t      awaddr_o,
	output logic                     wvalid_o,
	input  logic                     wready_i,
	output ls_types_pkg::data_t      wdata_o,
	input  logic                     bvalid_i,
	output logic                     bready_o,
	input  ls_ctrl_pkg::axi_resp_t   bresp_i,
	output logic                     arvalid_o,
	input  logic                     arready_i,
	output ls_types_pkg::addr_t      araddr_o,
	input  logic                     rvalid_i,
	output logic                     rready_o,
	input  ls_types_pkg::data_t      rdata_i,
	input  ls_ctrl_pkg::axi_resp_t   rresp_i,
	// results
	output logic                     result_valid_o,
	output ls_types_pkg::ptr_t       result_entry_o,
	output ls_types_pkg::data_t      result_data_o,
	output logic                     result_err_o
);
	import ls_types_pkg::*;

	ptr_t head_ptr;

	ls_head_if u_head_if ();

	ls_queue u_queue (
		.clk            (clk),
		.rst_n          (rst_n),
		.alloc_valid_i  (alloc_valid_i),
		.alloc_op_i     (alloc_op_i),
		.alloc_base_i   (alloc_base_i),
		.alloc_offset_i (alloc_offset_i),
		.alloc_data_i   (alloc_data_i),
		.alloc_tag_i    (alloc_tag_i),
		.alloc_ready_o  (alloc_ready_o),
		.cdb_valid_i    (cdb_valid_i),
		.cdb_tag_i      (cdb_tag_i),
		.cdb_data_i     (cdb_data_i),
		.head           (u_head_if),
		.head_ptr_o     (head_ptr)
	);

	ls_mem_ctrl u_mem_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.head           (u_head_if),
		.head_ptr_i     (head_ptr),
		.awvalid_o      (awvalid_o),
		.awready_i      (awready_i),
		.awaddr_o       (awaddr_o),
		.wvalid_o       (wvalid_o),
		.wready_i       (wready_i),
		.wdata_o        (wdata_o),
		.bvalid_i       (bvalid_i),
		.bready_o       (bready_o),
		.bresp_i        (bresp_i),
		.arvalid_o      (arvalid_o),
		.arready_i      (arready_i),
		.araddr_o       (araddr_o),
		.rvalid_i       (rvalid_i),
		.rready_o       (rready_o),
		.rdata_i        (rdata_i),
		.rresp_i        (rresp_i),
		.result_valid_o (result_valid_o),
		.result_entry_o (result_entry_o),
		.result_data_o  (result_data_o),
		.result_err_o   (result_err_o)
	);

endmodule

`default_nettype wire

// File: design/ls_ctrl_pkg.sv
`default_nettype none

package ls_ctrl_pkg;

	// head access sequence
	typedef enum logic [1:0] {
		MS_IDLE = 2'd0,
		MS_ADDR = 2'd1,
		MS_RESP = 2'd2,
		MS_DONE = 2'd3
	} mem_state_e;

	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: design/ls_entry.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_buffer_params.svh"

module ls_entry (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  write_i,
	input  ls_types_pkg::ls_op_e  op_i,
	input  ls_types_pkg::addr_t   addr_i,
	input  ls_types_pkg::data_t   data_i,
	input  ls_types_pkg::tag_t    tag_i,
	input  logic                  free_i,
	input  logic                  cdb_valid_i,
	input  ls_types_pkg::tag_t    cdb_tag_i,
	input  ls_types_pkg::data_t   cdb_data_i,
	output logic                  busy_o,
	output ls_types_pkg::ls_op_e  op_o,
	output ls_types_pkg::addr_t   addr_o,
	output ls_types_pkg::data_t   data_o,
	output logic                  ready_o
);
	import ls_types_pkg::*;

	logic   busy_q;
	ls_op_e op_q;
	addr_t  addr_q;
	data_t  data_q;
	tag_t   tag_q;
	logic   snoop_hit;
	logic   snoop_new;

	// waiting entry sees its producer on the bus
	assign snoop_hit = busy_q && cdb_valid_i && (tag_q != `LS_TAG_NONE) && (tag_q == cdb_tag_i);
	// producer broadcasts on the allocating edge itself
	assign snoop_new = cdb_valid_i && (tag_i != `LS_TAG_NONE) && (tag_i == cdb_tag_i);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			tag_q  <= `LS_TAG_NONE;
		end else if (write_i) begin
			busy_q <= 1'b1;
			tag_q  <= snoop_new ? `LS_TAG_NONE : tag_i;
		end else begin
			if (free_i)
				busy_q <= 1'b0;
			if (snoop_hit)
				tag_q <= `LS_TAG_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (write_i) begin
			op_q   <= op_i;
			addr_q <= addr_i;
			data_q <= snoop_new ? cdb_data_i : data_i;
		end else if (snoop_hit) begin
			data_q <= cdb_data_i;
		end
	end

	assign busy_o  = busy_q;
	assign op_o    = op_q;
	assign addr_o  = addr_q;
	assign data_o  = data_q;
	// loads never wait on a producer
	assign ready_o = (tag_q == `LS_TAG_NONE) || (op_q == LS_LOAD);

endmodule

`default_nettype wire

// File: design/ls_head_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ls_head_if;
	import ls_types_pkg::*;

	// contents of the entry at the head pointer
	logic   head_valid;
	ls_op_e head_op;
	addr_t  head_addr;
	data_t  head_data;
	logic   head_ready;

	// one cycle pulse, frees the head entry
	logic   retire;

	modport queue (
		output head_valid, head_op, head_addr, head_data, head_ready,
		input  retire
	);

	modport ctrl (
		input  head_valid, head_op, head_addr, head_data, head_ready,
		output retire
	);

endinterface

`default_nettype wire

// File: design/ls_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ls_mem_ctrl (
	input  logic                     clk,
	input  logic                     rst_n,
	ls_head_if.ctrl                  head,
	input  ls_types_pkg::ptr_t       head_ptr_i,
	output logic                     awvalid_o,
	input  logic                     awready_i,
	output ls_types_pkg::addr_t      awaddr_o,
	output logic                     wvalid_o,
	input  logic                     wready_i,
	output ls_types_pkg::data_t      wdata_o,
	input  logic                     bvalid_i,
	output logic                     bready_o,
	input  ls_ctrl_pkg::axi_resp_t   bresp_i,
	output logic                     arvalid_o,
	input  logic                     arready_i,
	output ls_types_pkg::addr_t      araddr_o,
	input  logic                     rvalid_i,
	output logic                     rready_o,
	input  ls_types_pkg::data_t      rdata_i,
	input  ls_ctrl_pkg::axi_resp_t   rresp_i,
	output logic                     result_valid_o,
	output ls_types_pkg::ptr_t       result_entry_o,
	output ls_types_pkg::data_t      result_data_o,
	output logic                     result_err_o
);
	import ls_types_pkg::*;
	import ls_ctrl_pkg::*;

	mem_state_e state_q;
	logic       awvalid_q;
	logic       wvalid_q;
	logic       arvalid_q;
	logic       bready_q;
	logic       rready_q;
	ls_op_e     op_q;
	addr_t      addr_q;
	data_t      data_q;
	ptr_t       entry_q;
	data_t      res_data_q;
	logic       res_err_q;
	logic       issue;
	logic       aw_fin;
	logic       w_fin;
	logic       b_fire;
	logic       r_fire;

	assign issue  = (state_q == MS_IDLE) && head.head_valid && head.head_ready;
	// each channel is finished once its valid has dropped or transfers now
	assign aw_fin = !awvalid_q || awready_i;
	assign w_fin  = !wvalid_q || wready_i;
	assign b_fire = bready_q && bvalid_i;
	assign r_fire = rready_q && rvalid_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q   <= MS_IDLE;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			arvalid_q <= 1'b0;
			bready_q  <= 1'b0;
			rready_q  <= 1'b0;
		end else begin
			case (state_q)
				MS_IDLE: begin
					if (issue) begin
						state_q <= MS_ADDR;
						if (head.head_op == LS_STORE) begin
							awvalid_q <= 1'b1;
							wvalid_q  <= 1'b1;
						end else begin
							arvalid_q <= 1'b1;
						end
					end
				end
				MS_ADDR: begin
					if (op_q == LS_STORE) begin
						if (awready_i)
							awvalid_q <= 1'b0;
						if (wready_i)
							wvalid_q <= 1'b0;
						if (aw_fin && w_fin) begin
							state_q  <= MS_RESP;
							bready_q <= 1'b1;
						end
					end else if (arvalid_q && arready_i) begin
						arvalid_q <= 1'b0;
						state_q   <= MS_RESP;
						rready_q  <= 1'b1;
					end
				end
				MS_RESP: begin
					if (b_fire) begin
						bready_q <= 1'b0;
						state_q  <= MS_DONE;
					end
					if (r_fire) begin
						rready_q <= 1'b0;
						state_q  <= MS_DONE;
					end
				end
				default: state_q <= MS_IDLE;
			endcase
		end
	end

	// access payload and the result word
	always_ff @(posedge clk) begin
		if (issue) begin
			op_q    <= head.head_op;
			addr_q  <= head.head_addr;
			data_q  <= head.head_data;
			entry_q <= head_ptr_i;
		end
		if (b_fire) begin
			res_data_q <= '0;
			res_err_q  <= (bresp_i != RESP_OKAY);
		end
		if (r_fire) begin
			res_data_q <= rdata_i;
			res_err_q  <= (rresp_i != RESP_OKAY);
		end
	end

	assign awvalid_o = awvalid_q;
	assign awaddr_o  = addr_q;
	assign wvalid_o  = wvalid_q;
	assign wdata_o   = data_q;
	assign bready_o  = bready_q;
	assign arvalid_o = arvalid_q;
	assign araddr_o  = addr_q;
	assign rready_o  = rready_q;

	// head pointer advances on the same edge that leaves MS_DONE
	assign head.retire    = (state_q == MS_DONE);
	assign result_valid_o = (state_q == MS_DONE);
	assign result_entry_o = entry_q;
	assign result_data_o  = res_data_q;
	assign result_err_o   = res_err_q;

endmodule

`default_nettype wire

// File: design/ls_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_buffer_params.svh"

module ls_queue (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  alloc_valid_i,
	input  ls_types_pkg::ls_op_e  alloc_op_i,
	input  ls_types_pkg::addr_t   alloc_base_i,
	input  ls_types_pkg::addr_t   alloc_offset_i,
	input  ls_types_pkg::data_t   alloc_data_i,
	input  ls_types_pkg::tag_t    alloc_tag_i,
	output logic                  alloc_ready_o,
	input  logic                  cdb_valid_i,
	input  ls_types_pkg::tag_t    cdb_tag_i,
	input  ls_types_pkg::data_t   cdb_data_i,
	ls_head_if.queue              head,
	output ls_types_pkg::ptr_t    head_ptr_o
);
	import ls_types_pkg::*;

	localparam logic [`LS_PTR_W-1:0] FULL_COUNT = `LS_ENTRIES;

	ptr_t                    tail_q;
	ptr_t                    head_q;
	logic [`LS_PTR_W-1:0]    count_q;
	logic                    alloc_fire;
	addr_t                   eff_addr;
	logic [`LS_ENTRIES-1:0]  write_sel;
	logic [`LS_ENTRIES-1:0]  free_sel;
	logic [`LS_ENTRIES-1:0]  busy;
	logic [`LS_ENTRIES-1:0]  ready;
	ls_op_e                  ent_op   [`LS_ENTRIES];
	addr_t                   ent_addr [`LS_ENTRIES];
	data_t                   ent_data [`LS_ENTRIES];

	function automatic ptr_t ptr_inc(input ptr_t p);
		ptr_inc = (p == ptr_t'(`LS_ENTRIES - 1)) ? '0 : p + ptr_t'(1);
	endfunction

	assign alloc_ready_o = (count_q != FULL_COUNT);
	assign alloc_fire    = alloc_valid_i && alloc_ready_o;
	assign eff_addr      = alloc_base_i + alloc_offset_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tail_q  <= '0;
			head_q  <= '0;
			count_q <= '0;
		end else begin
			if (alloc_fire)
				tail_q <= ptr_inc(tail_q);
			if (head.retire)
				head_q <= ptr_inc(head_q);
			case ({alloc_fire, head.retire})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	genvar i;
	for (i = 0; i < `LS_ENTRIES; i++) begin : g_entry
		assign write_sel[i] = alloc_fire && (tail_q == ptr_t'(i));
		assign free_sel[i]  = head.retire && (head_q == ptr_t'(i));

		ls_entry u_entry (
			.clk         (clk),
			.rst_n       (rst_n),
			.write_i     (write_sel[i]),
			.op_i        (alloc_op_i),
			.addr_i      (eff_addr),
			.data_i      (alloc_data_i),
			.tag_i       (alloc_tag_i),
			.free_i      (free_sel[i]),
			.cdb_valid_i (cdb_valid_i),
			.cdb_tag_i   (cdb_tag_i),
			.cdb_data_i  (cdb_data_i),
			.busy_o      (busy[i]),
			.op_o        (ent_op[i]),
			.addr_o      (ent_addr[i]),
			.data_o      (ent_data[i]),
			.ready_o     (ready[i])
		);
	end

	// head entry view for the controller
	assign head.head_valid = busy[head_q];
	assign head.head_op    = ent_op[head_q];
	assign head.head_addr  = ent_addr[head_q];
	assign head.head_data  = ent_data[head_q];
	assign head.head_ready = ready[head_q];
	assign head_ptr_o      = head_q;

endmodule

`default_nettype wire

// File: design/ls_types_pkg.sv
`default_nettype none

`include "ls_buffer_params.svh"

package ls_types_pkg;

	// memory address and data word
	typedef logic [`LS_ADDR_W-1:0] addr_t;
	typedef logic [`LS_DATA_W-1:0] data_t;

	// tag of the unit producing a store value
	typedef logic [`LS_TAG_W-1:0] tag_t;

	// buffer entry index
	typedef logic [`LS_PTR_W-1:0] ptr_t;

	typedef enum logic {
		LS_LOAD  = 1'b0,
		LS_STORE = 1'b1
	} ls_op_e;

endpackage

`default_nettype wire

// File: files.f
+incdir+include
design/ls_types_pkg.sv
design/ls_ctrl_pkg.sv
design/ls_head_if.sv
design/ls_entry.sv
design/ls_queue.sv
design/ls_mem_ctrl.sv
design/ls_buffer_top.sv
test/ls_buffer_properties.sv
test/ls_buffer_tb.sv

// File: include/ls_buffer_params.svh
`ifndef LS_BUFFER_PARAMS_SVH
`define LS_BUFFER_PARAMS_SVH

// buffer depth
`define LS_ENTRIES 6

// entry index width, wide enough for 0 to LS_ENTRIES
`define LS_PTR_W 3

// data path widths
`define LS_ADDR_W 32
`define LS_DATA_W 32

// producer tags, zero means the value is already present
`define LS_TAG_W 4
`define LS_TAG_NONE 4'd0

`endif

// File: test/ls_buffer_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ls_buffer_properties (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 awvalid_i,
	input logic                 awready_i,
	input ls_types_pkg::addr_t  awaddr_i,
	input logic                 wvalid_i,
	input logic                 wready_i,
	input ls_types_pkg::data_t  wdata_i,
	input logic                 arvalid_i,
	input logic                 arready_i,
	input ls_types_pkg::addr_t  araddr_i,
	input logic                 result_valid_i
);

	// valid holds with a stable payload until the transfer
	a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
		else $error("AW valid dropped or address changed before the transfer");

	a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
		else $error("W valid dropped or data changed before the transfer");

	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
		else $error("AR valid dropped or address changed before the transfer");

	// one access in flight at a time
	a_one_access: assert property (@(posedge clk) disable iff (!rst_n)
		!(awvalid_i && arvalid_i))
		else $error("read and write address channels active together");

	a_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid_i |=> !result_valid_i)
		else $error("result valid held for more than one cycle");

endmodule

bind ls_mem_ctrl ls_buffer_properties u_properties (
	.clk            (clk),
	.rst_n          (rst_n),
	.awvalid_i      (awvalid_o),
	.awready_i      (awready_i),
	.awaddr_i       (awaddr_o),
	.wvalid_i       (wvalid_o),
	.wready_i       (wready_i),
	.wdata_i        (wdata_o),
	.arvalid_i      (arvalid_o),
	.arready_i      (arready_i),
	.araddr_i       (araddr_o),
	.result_valid_i (result_valid_o)
);

`default_nettype wire

// File: test/ls_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_buffer_params.svh"

module ls_buffer_tb;
	import ls_types_pkg::*;
	import ls_ctrl_pkg::*;

	localparam int N_RANDOM     = 200;
	localparam int DIRECTED_OPS = 31;
	localparam int TOTAL_OPS    = DIRECTED_OPS + N_RANDOM;
	localparam int RESET_CYC    = 16;
	localparam int N_TESTS      = 6;

	logic      clk;
	logic      rst_n;
	logic      alloc_valid_i;
	ls_op_e    alloc_op_i;
	addr_t     alloc_base_i;
	addr_t     alloc_offset_i;
	data_t     alloc_data_i;
	tag_t      alloc_tag_i;
	logic      alloc_ready_o;
	logic      cdb_valid_i;
	tag_t      cdb_tag_i;
	data_t     cdb_data_i;
	logic      awvalid_o;
	logic      awready_i;
	addr_t     awaddr_o;
	logic      wvalid_o;
	logic      wready_i;
	data_t     wdata_o;
	logic      bvalid_i;
	logic      bready_o;
	axi_resp_t bresp_i;
	logic      arvalid_o;
	logic      arready_i;
	addr_t     araddr_o;
	logic      rvalid_i;
	logic      rready_o;
	data_t     rdata_i;
	axi_resp_t rresp_i;
	logic      result_valid_o;
	ptr_t      result_entry_o;
	data_t     result_data_o;
	logic      result_err_o;

	// slave memory and the reference copy of it
	data_t       mem [64];
	data_t       shadow [64];
	logic        mem_hold;
	// expected {err, entry, data} in allocation order
	logic [35:0] exp_q [$];
	int          exp_test_q [$];
	tag_t        pending_tag [$];
	data_t       pending_data [$];
	int          checks [N_TESTS];
	int          fails [N_TESTS];
	int          alloc_count;
	int          results_seen;
	int          cur_test;
	string       test_names [N_TESTS] = '{"preload_loads", "store_then_load", "tagged_store",
		"full_buffer", "error_resp", "random_mix"};

	ls_buffer_top u_ls_buffer_top (.*);

	initial begin : clock_gen
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin : watchdog
		#((TOTAL_OPS * 40 + RESET_CYC) * 20);
		$display("Timeout: the tests did not finish within %0d cycles", TOTAL_OPS * 40 + RESET_CYC);
		$display("FAIL: see errors above");
		$finish;
	end

	// preload pattern over the whole byte address
	function automatic data_t fill_word(input addr_t addr);
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	// {err, data} of the next access in allocation order against the shadow memory
	function automatic logic [32:0] ls_expect(input ls_op_e op, input addr_t addr,
		input data_t data);
		if (addr >= 32'h80)
			return {1'b1, 32'h0};
		if (op == LS_STORE) begin
			shadow[addr[7:2]] = data;
			return {1'b0, 32'h0};
		end
		return {1'b0, shadow[addr[7:2]]};
	endfunction

	// err, entry and data of one result as text
	function automatic string result_text(input logic [35:0] r);
		return $sformatf("err %0b entry %0d data %08h", r[35], r[34:32], r[31:0]);
	endfunction

	function automatic tag_t free_tag();
		tag_t t;
		logic used;
		t = tag_t'(1 + $urandom % 14);
		do begin
			used = 1'b0;
			foreach (pending_tag[j])
				if (pending_tag[j] == t)
					used = 1'b1;
			if (used)
				t = (t == 4'd14) ? 4'd1 : t + 4'd1;
		end while (used);
		return t;
	endfunction

	// drives the allocation port for the next edge
	task automatic present_alloc(input ls_op_e op, input addr_t addr, input data_t imm,
		input tag_t tag, input data_t resolved);
		addr_t      base;
		logic [32:0] res;
		base           = $urandom;
		alloc_valid_i  = 1'b1;
		alloc_op_i     = op;
		alloc_base_i   = base;
		alloc_offset_i = addr - base;
		alloc_data_i   = imm;
		alloc_tag_i    = tag;
		res = ls_expect(op, addr, (tag == '0) ? imm : resolved);
		exp_q.push_back({res[32], ptr_t'(alloc_count % `LS_ENTRIES), res[31:0]});
		exp_test_q.push_back(cur_test);
		alloc_count++;
	endtask

	task automatic alloc(input ls_op_e op, input addr_t addr, input data_t imm,
		input tag_t tag, input data_t resolved);
		while (!alloc_ready_o) begin
			@(posedge clk);
			#2;
		end
		present_alloc(op, addr, imm, tag, resolved);
		@(posedge clk);
		#2;
		alloc_valid_i = 1'b0;
	endtask

	task automatic bus_send(input tag_t tag, input data_t data);
		cdb_valid_i = 1'b1;
		cdb_tag_i   = tag;
		cdb_data_i  = data;
		@(posedge clk);
		#2;
		cdb_valid_i = 1'b0;
	endtask

	task automatic check_ready(input logic want);
		checks[cur_test]++;
		if (alloc_ready_o !== want) begin
			$display("Error: %s alloc_ready_o expected %0b actual %0b",
				test_names[cur_test], want, alloc_ready_o);
			fails[cur_test]++;
		end
	endtask

	task automatic watch_no_store(input int n);
		repeat (n) begin
			checks[cur_test]++;
			if (awvalid_o) begin
				$display("Error: %s store reached memory before its tag was broadcast",
					test_names[cur_test]);
				fails[cur_test]++;
			end
			@(posedge clk);
			#2;
		end
	endtask

	task automatic drain_and_report();
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
		$display("test %0d %s: %0d checks, %0d errors", cur_test, test_names[cur_test],
			checks[cur_test], fails[cur_test]);
	endtask

	// 0 to 3 cycles of slave latency plus any memory hold
	task automatic slave_delay();
		int n;
		n = $urandom % 4;
		repeat (n) begin
			@(posedge clk);
			#2;
		end
		while (mem_hold) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic mem_read();
		addr_t addr;
		slave_delay();
		addr      = araddr_o;
		arready_i = 1'b1;
		@(posedge clk);
		#2;
		arready_i = 1'b0;
		slave_delay();
		rvalid_i = 1'b1;
		rresp_i  = (addr >= 32'h80) ? 2'b10 : RESP_OKAY;
		rdata_i  = (addr >= 32'h80) ? '0 : mem[addr[7:2]];
		while (!rready_o) begin
			@(posedge clk);
			#2;
		end
		@(posedge clk);
		#2;
		rvalid_i = 1'b0;
	endtask

	task automatic mem_write();
		addr_t addr;
		data_t data;
		int    aw_wait;
		int    w_wait;
		logic  aw_done;
		logic  w_done;
		logic  aw_xfer;
		logic  w_xfer;
		aw_wait = $urandom % 4;
		w_wait  = $urandom % 4;
		aw_done = 1'b0;
		w_done  = 1'b0;
		// address and data channels accepted independently
		while (!(aw_done && w_done)) begin
			awready_i = !aw_done && (aw_wait == 0) && !mem_hold;
			wready_i  = !w_done && (w_wait == 0) && !mem_hold;
			aw_xfer   = awready_i && awvalid_o;
			w_xfer    = wready_i && wvalid_o;
			if (aw_xfer)
				addr = awaddr_o;
			if (w_xfer)
				data = wdata_o;
			if (aw_wait > 0)
				aw_wait--;
			if (w_wait > 0)
				w_wait--;
			@(posedge clk);
			#2;
			aw_done = aw_done || aw_xfer;
			w_done  = w_done || w_xfer;
		end
		awready_i = 1'b0;
		wready_i  = 1'b0;
		slave_delay();
		if (addr < 32'h80)
			mem[addr[7:2]] = data;
		bresp_i  = (addr >= 32'h80) ? 2'b10 : RESP_OKAY;
		bvalid_i = 1'b1;
		while (!bready_o) begin
			@(posedge clk);
			#2;
		end
		@(posedge clk);
		#2;
		bvalid_i = 1'b0;
	endtask

	initial begin : axi_slave
		forever begin
			@(posedge clk);
			#2;
			if (rst_n && arvalid_o)
				mem_read();
			else if (rst_n && awvalid_o)
				mem_write();
		end
	end

	initial begin : compare
		logic [35:0] want;
		logic [35:0] got;
		int          t;
		forever begin
			@(negedge clk);
			if (rst_n && result_valid_o) begin
				results_seen++;
				got = {result_err_o, result_entry_o, result_data_o};
				if (exp_q.size() == 0) begin
					$display("Error: result from entry %0d arrived with nothing outstanding",
						result_entry_o);
					fails[cur_test]++;
				end else begin
					want = exp_q.pop_front();
					t    = exp_test_q.pop_front();
					checks[t]++;
					if (got !== want) begin
						$display("Error: %s expected %s actual %s", test_names[t],
							result_text(want), result_text(got));
						fails[t]++;
					end
				end
			end
		end
	end

	initial begin : stimulus
		int     rnd;
		int     n;
		int     k;
		int     base_seen;
		int     total_checks;
		int     total_fails;
		ls_op_e op;
		addr_t  a;
		data_t  d;
		tag_t   tg;
		rnd            = $urandom(3);
		rst_n          = 1'b0;
		alloc_valid_i  = 1'b0;
		alloc_op_i     = LS_LOAD;
		alloc_base_i   = '0;
		alloc_offset_i = '0;
		alloc_data_i   = '0;
		alloc_tag_i    = '0;
		cdb_valid_i    = 1'b0;
		cdb_tag_i      = '0;
		cdb_data_i     = '0;
		awready_i      = 1'b0;
		wready_i       = 1'b0;
		bvalid_i       = 1'b0;
		bresp_i        = RESP_OKAY;
		arready_i      = 1'b0;
		rvalid_i       = 1'b0;
		rdata_i        = '0;
		rresp_i        = RESP_OKAY;
		mem_hold       = 1'b0;
		alloc_count    = 0;
		results_seen   = 0;
		cur_test       = 0;
		for (int i = 0; i < 64; i++) begin
			mem[i]    = fill_word(addr_t'(i * 4));
			shadow[i] = fill_word(addr_t'(i * 4));
		end
		repeat (RESET_CYC) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// eight loads wrap the entry index past 5
		check_ready(1'b1);
		for (int i = 0; i < 8; i++)
			alloc(LS_LOAD, addr_t'(i * 12), '0, '0, '0);
		drain_and_report();

		cur_test = 1;
		d = $urandom;
		alloc(LS_STORE, 32'h40, d, '0, '0);
		alloc(LS_LOAD, 32'h40, '0, '0, '0);
		alloc(LS_STORE, 32'h44, ~d, '0, '0);
		alloc(LS_LOAD, 32'h44, '0, '0, '0);
		drain_and_report();

		cur_test = 2;
		d = $urandom;
		alloc(LS_STORE, 32'h20, ~d, 4'd5, d);
		alloc(LS_LOAD, 32'h20, '0, '0, '0);
		// unrelated producer must not wake the store
		bus_send(4'd6, ~d);
		watch_no_store(8);
		bus_send(4'd5, d);
		// producer broadcasts on the allocating edge
		d = $urandom;
		cdb_valid_i = 1'b1;
		cdb_tag_i   = 4'd7;
		cdb_data_i  = d;
		alloc(LS_STORE, 32'h24, ~d, 4'd7, d);
		cdb_valid_i = 1'b0;
		alloc(LS_LOAD, 32'h24, '0, '0, '0);
		drain_and_report();

		cur_test = 3;
		mem_hold = 1'b1;
		for (int i = 0; i < `LS_ENTRIES; i++)
			alloc(LS_LOAD, addr_t'(32'h60 + i * 4), '0, '0, '0);
		base_seen = results_seen;
		repeat (4) begin
			check_ready(1'b0);
			@(posedge clk);
			#2;
		end
		@(negedge clk);
		mem_hold = 1'b0;
		@(posedge clk);
		#2;
		while (!alloc_ready_o) begin
			@(posedge clk);
			#2;
		end
		checks[cur_test]++;
		if (results_seen != base_seen + 1) begin
			$display("Error: full_buffer allocation resumed after %0d completions instead of one",
				results_seen - base_seen);
			fails[cur_test]++;
		end
		alloc(LS_LOAD, 32'h68, '0, '0, '0);
		alloc(LS_STORE, 32'h60, $urandom, '0, '0);
		alloc(LS_LOAD, 32'h60, '0, '0, '0);
		drain_and_report();

		cur_test = 4;
		alloc(LS_LOAD, 32'h84, '0, '0, '0);
		alloc(LS_STORE, 32'hc0, $urandom, '0, '0);
		alloc(LS_LOAD, 32'h1000_0000, '0, '0, '0);
		alloc(LS_LOAD, 32'h10, '0, '0, '0);
		alloc(LS_STORE, 32'h14, $urandom, '0, '0);
		alloc(LS_LOAD, 32'h14, '0, '0, '0);
		drain_and_report();

		cur_test = 5;
		n = 0;
		while (n < N_RANDOM || pending_tag.size() != 0) begin
			alloc_valid_i = 1'b0;
			cdb_valid_i   = 1'b0;
			if (n < N_RANDOM && alloc_ready_o && ($urandom % 4 != 0)) begin
				op = ($urandom % 2) ? LS_STORE : LS_LOAD;
				a  = addr_t'(($urandom % 40) * 4);
				d  = $urandom;
				tg = '0;
				if (op == LS_STORE && ($urandom % 2)) begin
					tg = free_tag();
					pending_tag.push_back(tg);
					pending_data.push_back(d);
				end
				present_alloc(op, a, (tg == '0) ? d : ~d, tg, d);
				n++;
			end
			if (pending_tag.size() != 0 && ($urandom % 3 == 0)) begin
				k           = $urandom % pending_tag.size();
				cdb_valid_i = 1'b1;
				cdb_tag_i   = pending_tag[k];
				cdb_data_i  = pending_data[k];
				pending_tag.delete(k);
				pending_data.delete(k);
			end else if ($urandom % 8 == 0) begin
				// tag 15 is never handed out
				cdb_valid_i = 1'b1;
				cdb_tag_i   = 4'd15;
				cdb_data_i  = $urandom;
			end
			@(posedge clk);
			#2;
		end
		alloc_valid_i = 1'b0;
		cdb_valid_i   = 1'b0;
		drain_and_report();

		total_checks = 0;
		total_fails  = 0;
		for (int i = 0; i < N_TESTS; i++) begin
			total_checks += checks[i];
			total_fails  += fails[i];
		end
		$display("summary: %0d tests, %0d checks, %0d errors", N_TESTS, total_checks, total_fails);
		if (total_fails == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
